// ==== filelist.f ====
lockin_regs_pkg.sv
lockin_dsp_pkg.sv
apb_param_regs.sv
position_frontend.sv
tweezer_pi.sv
dac_serializer.sv
tweezer_lockin_top.sv
tb_tweezer_lockin.sv

// ==== Bender.yml ====
package:
  name: tweezer_lockin

sources:
  - lockin_regs_pkg.sv
  - lockin_dsp_pkg.sv
  - apb_param_regs.sv
  - position_frontend.sv
  - tweezer_pi.sv
  - dac_serializer.sv
  - tweezer_lockin_top.sv
  - target: test
    files:
      - tb_tweezer_lockin.sv

// ==== tb_tweezer_lockin.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tweezer_lockin import lockin_regs_pkg::*, lockin_dsp_pkg::*; ();

	localparam time clk_period   = 100;
	localparam int  reset_cycles = 8;
	// cycles any single wait may take
	localparam int  wait_limit   = 500;

	logic        clk_50;
	logic        arst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	adc_sample_t adc;
	logic        adc_valid;
	logic        dac_sck;
	logic [3:0]  dac_cs_n;
	logic [3:0]  dac_sdo;

	logic [31:0] lfsr_state;

	// reference copy of the register contents and integrator
	bit     m_enable;
	int     m_kp;
	int     m_ki;
	int     m_setpoint;
	int     m_lim_hi;
	int     m_lim_lo;
	int     m_out_dis;
	int     m_offset;
	longint m_integ;

	tweezer_lockin_top i_dut (
		.clk_50    (clk_50),
		.arst_n    (arst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.adc       (adc),
		.adc_valid (adc_valid),
		.dac_sck   (dac_sck),
		.dac_cs_n  (dac_cs_n),
		.dac_sdo   (dac_sdo)
	);

	always #(clk_period / 2) clk_50 = ~clk_50;

	task automatic stop_on_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR at %0d ns: %s is %h, expected %h", $time, sig, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "value mismatch");
	endtask

	task automatic stop_with(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, what);
	endtask

	task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else stop_on_mismatch(sig, got, exp);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int to_s16(input logic [15:0] v);
		return int'(signed'(v));
	endfunction

	function automatic int to_s26(input logic [25:0] v);
		return int'(signed'(v));
	endfunction

	function automatic adc_sample_t random_sample();
		adc_sample_t s;
		s.a = rand_bits(16);
		s.b = rand_bits(16);
		s.c = rand_bits(16);
		s.d = rand_bits(16);
		return s;
	endfunction

	function automatic int sat16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	function automatic longint clamp_model(input longint v, input longint lo, input longint hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// 16-bit wrap after adding the mid code
	function automatic logic [15:0] offset_binary(input int v);
		logic [15:0] lo;
		lo = v[15:0];
		return lo + 16'h8000;
	endfunction

	// a channel reads full scale at either rail
	function automatic logic [3:0] flags_model(input adc_sample_t s);
		logic [3:0] f;
		f[0] = (s.a == 16'h7FFF) || (s.a == 16'h8000);
		f[1] = (s.b == 16'h7FFF) || (s.b == 16'h8000);
		f[2] = (s.c == 16'h7FFF) || (s.c == 16'h8000);
		f[3] = (s.d == 16'h7FFF) || (s.d == 16'h8000);
		return f;
	endfunction

	// next controller output, integrator advanced by one sample
	function automatic int pi_model(input int pos);
		longint err;
		longint p;
		longint step;
		err  = m_setpoint - pos;
		p    = (longint'(m_kp) * err) >>> 24;
		step = (longint'(m_ki) * err) >>> 24;
		if (!m_enable) begin
			m_integ = 0;
			return m_out_dis;
		end
		m_integ = clamp_model(m_integ + step, m_lim_lo, m_lim_hi);
		return int'(clamp_model(p + m_integ, m_lim_lo, m_lim_hi));
	endfunction

	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int waits;
		// setup phase
		@(posedge clk_50);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		// access phase
		@(posedge clk_50);
		#1;
		apb_req.penable = 1'b1;
		waits = 0;
		@(negedge clk_50);
		while (apb_rsp.pready !== 1'b1) begin
			waits++;
			if (waits > wait_limit)
				stop_with("APB transfer never saw pready");
			@(negedge clk_50);
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk_50);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic set_reg(input logic [7:0] addr, input logic [31:0] data, input string name);
		logic err;
		apb_write(addr, data, err);
		check_value({name, " write pslverr"}, err, 0);
	endtask

	task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		check_value({name, " read pslverr"}, err, 0);
		check_value(name, data, exp);
	endtask

	task automatic reset_model();
		m_enable   = 1'b0;
		m_kp       = 0;
		m_ki       = 0;
		m_setpoint = 0;
		m_lim_hi   = 32767;
		m_lim_lo   = -32768;
		m_out_dis  = 0;
		m_offset   = 0;
		m_integ    = 0;
	endtask

	// loop disabled while reconfiguring, so the integrator ends at 0
	task automatic apply_model();
		set_reg(reg_ctrl, 32'h0, "ctrl");
		set_reg(reg_kp, m_kp, "kp");
		set_reg(reg_ki, m_ki, "ki");
		set_reg(reg_setpoint, m_setpoint, "setpoint");
		set_reg(reg_limit_hi, m_lim_hi, "limit_hi");
		set_reg(reg_limit_lo, m_lim_lo, "limit_lo");
		set_reg(reg_out_disabled, m_out_dis, "out_disabled");
		set_reg(reg_xdiff_offset, m_offset, "xdiff_offset");
		set_reg(reg_ctrl, {31'h0, m_enable}, "ctrl");
		m_integ = 0;
	endtask

	task automatic adc_push(input adc_sample_t s);
		@(posedge clk_50);
		#1;
		adc       = s;
		adc_valid = 1'b1;
		@(posedge clk_50);
		#1;
		adc_valid = 1'b0;
	endtask

	// shift in one frame on rising sck, then sit out the cs_n gap
	task automatic dac_capture(output logic [3:0][15:0] words);
		int   waits;
		int   b;
		int   i;
		logic sck_prev;
		words = '0;
		waits = 0;
		@(negedge clk_50);
		while (dac_cs_n !== 4'h0) begin
			waits++;
			if (waits > wait_limit)
				stop_with("DAC chip selects never went low");
			@(negedge clk_50);
		end
		sck_prev = dac_sck;
		for (b = 0; b < dac_w; b++) begin
			waits = 0;
			@(negedge clk_50);
			while (!(dac_sck === 1'b1 && sck_prev === 1'b0)) begin
				sck_prev = dac_sck;
				waits++;
				if (waits > wait_limit)
					stop_with("DAC serial clock stopped before 16 bits");
				@(negedge clk_50);
			end
			sck_prev = dac_sck;
			check_value("dac_cs_n", dac_cs_n, 4'h0);
			for (i = 0; i < n_dac; i++)
				words[i] = {words[i][14:0], dac_sdo[i]};
		end
		waits = 0;
		while (dac_cs_n !== 4'hF) begin
			waits++;
			if (waits > wait_limit)
				stop_with("DAC chip selects never returned high");
			@(negedge clk_50);
		end
		repeat (dac_gap + 1) @(posedge clk_50);
	endtask

	task automatic check_frame(input logic [3:0][15:0] got, input int ctrl, input int pos,
		input int xdiff);
		check_value("dac1", got[0], 16'h8000);
		check_value("dac2", got[1], offset_binary(ctrl));
		check_value("dac3", got[2], offset_binary(pos >>> 3));
		check_value("dac4", got[3], offset_binary(xdiff));
	endtask

	task automatic sample_and_check(input adc_sample_t s);
		int               pos;
		int               ctrl;
		logic [3:0][15:0] words;
		pos  = sat16(int'(s.d) - m_offset);
		ctrl = pi_model(pos);
		adc_push(s);
		dac_capture(words);
		check_frame(words, ctrl, pos, int'(s.d));
	endtask

	task automatic test_registers();
		logic [31:0] v;
		logic [31:0] data;
		logic        err;
		// reset values
		expect_reg(reg_ctrl, 32'h0, "ctrl");
		expect_reg(reg_kp, 32'h0, "kp");
		expect_reg(reg_ki, 32'h0, "ki");
		expect_reg(reg_setpoint, 32'h0, "setpoint");
		expect_reg(reg_limit_hi, 32'h7FFF, "limit_hi");
		expect_reg(reg_limit_lo, 32'h8000, "limit_lo");
		expect_reg(reg_out_disabled, 32'h0, "out_disabled");
		expect_reg(reg_xdiff_offset, 32'h0, "xdiff_offset");
		expect_reg(reg_status, 32'h0, "status");
		// upper bits beyond the field width read back as 0
		v = rand_bits(32);
		set_reg(reg_kp, v, "kp");
		expect_reg(reg_kp, v & 32'h03FF_FFFF, "kp");
		v = rand_bits(32);
		set_reg(reg_ki, v, "ki");
		expect_reg(reg_ki, v & 32'h03FF_FFFF, "ki");
		v = rand_bits(32);
		set_reg(reg_setpoint, v, "setpoint");
		expect_reg(reg_setpoint, v & 32'hFFFF, "setpoint");
		v = rand_bits(32);
		set_reg(reg_limit_hi, v, "limit_hi");
		expect_reg(reg_limit_hi, v & 32'hFFFF, "limit_hi");
		v = rand_bits(32);
		set_reg(reg_limit_lo, v, "limit_lo");
		expect_reg(reg_limit_lo, v & 32'hFFFF, "limit_lo");
		v = rand_bits(32);
		set_reg(reg_out_disabled, v, "out_disabled");
		expect_reg(reg_out_disabled, v & 32'hFFFF, "out_disabled");
		v = rand_bits(32);
		set_reg(reg_xdiff_offset, v, "xdiff_offset");
		expect_reg(reg_xdiff_offset, v & 32'hFFFF, "xdiff_offset");
		// reset bit is a pulse and reads 0
		set_reg(reg_ctrl, 32'h3, "ctrl");
		expect_reg(reg_ctrl, 32'h1, "ctrl");
		// unmapped address and read-only status
		apb_write(8'h24, rand_bits(32), err);
		check_value("pslverr on write to 0x24", err, 1);
		apb_read(8'h24, data, err);
		check_value("pslverr on read of 0x24", err, 1);
		check_value("prdata of 0x24", data, 32'h0);
		apb_write(reg_status, 32'hF, err);
		check_value("pslverr on status write", err, 1);
		expect_reg(reg_status, 32'h0, "status");
	endtask

	task automatic test_disabled();
		reset_model();
		m_out_dis = to_s16(rand_bits(16));
		m_offset  = to_s16(rand_bits(16));
		apply_model();
		repeat (2) sample_and_check(random_sample());
	endtask

	task automatic test_proportional();
		reset_model();
		m_enable   = 1'b1;
		m_kp       = to_s26(26'(rand_bits(25)));
		m_setpoint = to_s16(rand_bits(16));
		m_offset   = to_s16(rand_bits(16));
		// narrow limits so the output clamp is reached
		m_lim_hi   = 8192;
		m_lim_lo   = -8192;
		apply_model();
		repeat (8) sample_and_check(random_sample());
	endtask

	task automatic test_integrator();
		adc_sample_t      s;
		logic [3:0][15:0] words;
		reset_model();
		m_enable = 1'b1;
		// step of roughly 25 to 50 codes for an error of 1600
		m_ki     = to_s26(32'h40000 + rand_bits(18));
		m_lim_hi = 350;
		m_lim_lo = -350;
		apply_model();
		s   = random_sample();
		s.d = -16'sd1600;
		repeat (15) sample_and_check(s);
		// fifteen steps of at least 25 codes pass 350, so dac2 sits at limit_hi
		void'(pi_model(sat16(int'(s.d) - m_offset)));
		adc_push(s);
		dac_capture(words);
		check_value("dac2 at limit_hi", words[1], offset_binary(350));
		// restart from a single step
		set_reg(reg_ctrl, 32'h3, "ctrl");
		m_integ = 0;
		sample_and_check(s);
	endtask

	task automatic test_saturation();
		adc_sample_t s;
		s = '{a: 16'h7FFF, b: 16'h8000, c: 16'h0000, d: 16'h1234};
		sample_and_check(s);
		expect_reg(reg_status, flags_model(s), "status");
		s = '{a: 16'h0000, b: 16'h0000, c: 16'h8000, d: 16'h7FFF};
		sample_and_check(s);
		expect_reg(reg_status, flags_model(s), "status");
		s = '{a: 16'h0000, b: 16'h0000, c: 16'h0000, d: 16'h0000};
		sample_and_check(s);
		expect_reg(reg_status, flags_model(s), "status");
	endtask

	// hard stop in case a wait slips through
	initial begin
		#(clk_period * 200_000);
		stop_with("simulation ran past its time limit");
	end

	initial begin
		clk_50     = 1'b0;
		arst_n     = 1'b0;
		apb_req    = '0;
		adc        = '0;
		adc_valid  = 1'b0;
		lfsr_state = 32'h4a14_1a65;
		reset_model();
		repeat (reset_cycles) @(posedge clk_50);
		#1;
		arst_n = 1'b1;
		@(negedge clk_50);
		// idle outputs straight out of reset
		check_value("dac_cs_n", dac_cs_n, 4'hF);
		check_value("dac_sck", dac_sck, 0);
		check_value("dac_sdo", dac_sdo, 4'h0);
		check_value("ctrl_valid", i_dut.ctrl_valid, 0);
		test_registers();
		test_disabled();
		test_proportional();
		test_integrator();
		test_saturation();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tweezer_lockin_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tweezer_lockin_top import lockin_regs_pkg::*, lockin_dsp_pkg::*; (
	input  wire logic        clk_50,
	input  wire logic        arst_n,
	input  wire apb_req_t    apb_req,
	output apb_rsp_t         apb_rsp,
	input  wire adc_sample_t adc,
	input  wire logic        adc_valid,
	output logic             dac_sck,
	output logic [3:0]       dac_cs_n,
	output logic [3:0]       dac_sdo
);

	pi_cfg_t                    pi_cfg;
	logic signed [sample_w-1:0] xdiff_offset;
	logic [status_w-1:0]        sat_flags;
	logic signed [sample_w-1:0] position;
	logic signed [sample_w-1:0] xdiff_raw;
	logic                       position_valid;
	logic signed [sample_w-1:0] ctrl_out;
	logic                       ctrl_valid;
	logic signed [sample_w-1:0] position_out;
	logic signed [sample_w-1:0] xdiff_out;
	logic signed [sample_w-1:0] ray;
	dac_frame_t                 frame;

	apb_param_regs i_regs (
		.clk_50       (clk_50),
		.arst_n       (arst_n),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.sat_flags    (sat_flags),
		.pi_cfg       (pi_cfg),
		.xdiff_offset (xdiff_offset)
	);

	position_frontend i_frontend (
		.clk_50         (clk_50),
		.arst_n         (arst_n),
		.adc            (adc),
		.adc_valid      (adc_valid),
		.xdiff_offset   (xdiff_offset),
		.position       (position),
		.xdiff_raw      (xdiff_raw),
		.position_valid (position_valid),
		.sat_flags      (sat_flags)
	);

	tweezer_pi i_pi (
		.clk_50         (clk_50),
		.arst_n         (arst_n),
		.cfg            (pi_cfg),
		.position       (position),
		.xdiff_raw      (xdiff_raw),
		.position_valid (position_valid),
		.ctrl_out       (ctrl_out),
		.ctrl_valid     (ctrl_valid),
		.position_out   (position_out),
		.xdiff_out      (xdiff_out)
	);

	// shift kept apart from the add so it stays arithmetic
	assign ray = position_out >>> ray_shift;

	// offset binary for the dacs, sums wrap at 16 bits
	assign frame.dac1 = dac_mid;
	assign frame.dac2 = ctrl_out + dac_mid;
	assign frame.dac3 = ray + dac_mid;
	assign frame.dac4 = xdiff_out + dac_mid;

	dac_serializer i_dac (
		.clk_50 (clk_50),
		.arst_n (arst_n),
		.frame  (frame),
		.load   (ctrl_valid),
		.busy   (),
		.sck    (dac_sck),
		.cs_n   (dac_cs_n),
		.sdo    (dac_sdo)
	);

endmodule

`default_nettype wire

// ==== dac_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_serializer import lockin_dsp_pkg::*; (
	input  wire logic       clk_50,
	input  wire logic       arst_n,
	input  wire dac_frame_t frame,
	input  wire logic       load,
	output logic            busy,
	output logic            sck,
	output logic [3:0]      cs_n,
	output logic [3:0]      sdo
);

	localparam int cnt_w = $clog2(dac_w);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_gap
	} state_t;

	state_t                        state;
	logic [cnt_w-1:0]              bit_cnt;
	logic [n_dac-1:0][dac_w-1:0]   words;
	logic [n_dac-1:0][dac_w-1:0]   sr;
	logic                          start;
	logic                          shift_bit;

	// index 0 drives the first dac
	assign words     = {frame.dac4, frame.dac3, frame.dac2, frame.dac1};
	// loads while busy are dropped
	assign start     = load & (state == st_idle);
	// next bit goes out on the falling sck edge
	assign shift_bit = (state == st_shift) & sck;
	assign busy      = (state != st_idle);

	always_ff @(posedge clk_50) begin
		if (start)
			sr <= words;
		else if (shift_bit)
			for (int i = 0; i < n_dac; i++)
				sr[i] <= {sr[i][dac_w-2:0], 1'b0};
	end

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= st_idle;
			bit_cnt <= '0;
			sck     <= 1'b0;
			cs_n    <= '1;
			sdo     <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load) begin
						state   <= st_shift;
						bit_cnt <= '0;
						cs_n    <= '0;
						// msb is set up during the first low half
						for (int i = 0; i < n_dac; i++)
							sdo[i] <= words[i][dac_w-1];
					end
				end
				st_shift: begin
					if (!sck) begin
						// dac samples here
						sck <= 1'b1;
					end else begin
						sck <= 1'b0;
						if (bit_cnt == cnt_w'(dac_w - 1)) begin
							state   <= st_gap;
							bit_cnt <= '0;
							cs_n    <= '1;
							sdo     <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							for (int i = 0; i < n_dac; i++)
								sdo[i] <= sr[i][dac_w-2];
						end
					end
				end
				st_gap: begin
					// cs_n held high before accepting the next frame
					if (bit_cnt == cnt_w'(dac_gap - 1))
						state <= st_idle;
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tweezer_pi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tweezer_pi import lockin_dsp_pkg::*; (
	input  wire logic                        clk_50,
	input  wire logic                        arst_n,
	input  wire pi_cfg_t                     cfg,
	input  wire logic signed [sample_w-1:0]  position,
	input  wire logic signed [sample_w-1:0]  xdiff_raw,
	input  wire logic                        position_valid,
	output logic signed [sample_w-1:0]       ctrl_out,
	output logic                             ctrl_valid,
	output logic signed [sample_w-1:0]       position_out,
	output logic signed [sample_w-1:0]       xdiff_out
);

	localparam int err_w  = sample_w + 1;
	localparam int prod_w = coeff_w + err_w;

	logic signed [err_w-1:0]    err;
	logic signed [prod_w-1:0]   p_prod;
	logic signed [prod_w-1:0]   i_prod;
	logic                       valid_s1;
	logic signed [work_w-1:0]   p_s1;
	logic signed [work_w-1:0]   step_s1;
	logic signed [sample_w-1:0] pos_s1;
	logic signed [sample_w-1:0] xdiff_s1;
	logic signed [work_w-1:0]   lim_hi;
	logic signed [work_w-1:0]   lim_lo;
	logic signed [work_w-1:0]   integ;
	logic signed [work_w-1:0]   integ_base;
	logic signed [work_w-1:0]   integ_next;
	logic signed [work_w-1:0]   out_clamped;

	function automatic logic signed [work_w-1:0] clamp(
		input logic signed [work_w-1:0] v,
		input logic signed [work_w-1:0] lo,
		input logic signed [work_w-1:0] hi
	);
		if (v > hi)
			return hi;
		else if (v < lo)
			return lo;
		return v;
	endfunction

	// stage 1, error and both products
	always_comb begin
		err    = err_w'(cfg.setpoint) - err_w'(position);
		p_prod = cfg.kp * err;
		i_prod = cfg.ki * err;
	end

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n)
			valid_s1 <= 1'b0;
		else
			valid_s1 <= position_valid;
	end

	// >>> floors toward minus infinity
	always_ff @(posedge clk_50) begin
		if (position_valid) begin
			p_s1     <= work_w'(p_prod >>> coeff_frac);
			step_s1  <= work_w'(i_prod >>> coeff_frac);
			pos_s1   <= position;
			xdiff_s1 <= xdiff_raw;
		end
	end

	// stage 2, integrator and output clamp
	assign lim_hi = work_w'(cfg.limit_hi);
	assign lim_lo = work_w'(cfg.limit_lo);

	// a reset pulse restarts the integrator from zero
	assign integ_base  = cfg.reset_pulse ? '0 : integ;
	assign integ_next  = clamp(integ_base + step_s1, lim_lo, lim_hi);
	assign out_clamped = clamp(p_s1 + integ_next, lim_lo, lim_hi);

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			integ      <= '0;
			ctrl_valid <= 1'b0;
		end else begin
			ctrl_valid <= valid_s1;
			// disabled loop keeps integrator parked at 0
			if (!cfg.enable)
				integ <= '0;
			else if (valid_s1)
				integ <= integ_next;
			else if (cfg.reset_pulse)
				integ <= '0;
		end
	end

	always_ff @(posedge clk_50) begin
		if (valid_s1) begin
			ctrl_out     <= cfg.enable ? out_clamped[sample_w-1:0] : cfg.out_disabled;
			position_out <= pos_s1;
			xdiff_out    <= xdiff_s1;
		end
	end

endmodule

`default_nettype wire

// ==== position_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module position_frontend import lockin_dsp_pkg::*; (
	input  wire logic                        clk_50,
	input  wire logic                        arst_n,
	input  wire adc_sample_t                 adc,
	input  wire logic                        adc_valid,
	input  wire logic signed [sample_w-1:0]  xdiff_offset,
	output logic signed [sample_w-1:0]       position,
	output logic signed [sample_w-1:0]       xdiff_raw,
	output logic                             position_valid,
	output logic [3:0]                       sat_flags
);

	logic signed [sample_w:0]   diff;
	logic signed [sample_w-1:0] diff_sat;

	// a channel pinned at either rail
	function automatic logic full_scale(input logic [sample_w-1:0] s);
		return (s == sat_pos) || (s == sat_neg);
	endfunction

	// one guard bit, so the difference never wraps
	assign diff = (sample_w+1)'(adc.d) - (sample_w+1)'(xdiff_offset);

	// top two bits disagree means out of 16-bit range
	always_comb begin
		if (diff[sample_w] != diff[sample_w-1])
			diff_sat = diff[sample_w] ? sat_neg : sat_pos;
		else
			diff_sat = diff[sample_w-1:0];
	end

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			position_valid <= 1'b0;
			sat_flags      <= '0;
		end else begin
			position_valid <= adc_valid;
			// flags follow the last valid sample
			if (adc_valid)
				sat_flags <= {full_scale(adc.d), full_scale(adc.c),
					full_scale(adc.b), full_scale(adc.a)};
		end
	end

	always_ff @(posedge clk_50) begin
		if (adc_valid) begin
			xdiff_raw <= adc.d;
			position  <= diff_sat;
		end
	end

endmodule

`default_nettype wire

// ==== apb_param_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_param_regs import lockin_regs_pkg::*, lockin_dsp_pkg::*; (
	input  wire logic                    clk_50,
	input  wire logic                    arst_n,
	input  wire apb_req_t                apb_req,
	output apb_rsp_t                     apb_rsp,
	input  wire logic [status_w-1:0]     sat_flags,
	output pi_cfg_t                      pi_cfg,
	output logic signed [sample_w-1:0]   xdiff_offset
);

	pi_cfg_t                    cfg_q;
	logic signed [sample_w-1:0] xdiff_offset_q;
	logic                       access;
	logic                       addr_hit;
	logic                       status_wr;
	logic                       wr_en;
	logic [apb_data_w-1:0]      rdata;

	// access phase of a transfer, never any wait states
	assign access    = apb_req.psel & apb_req.penable;
	assign status_wr = apb_req.pwrite & (apb_req.paddr == reg_status);
	assign wr_en     = access & apb_req.pwrite & addr_hit & ~status_wr;

	// address decode and read mux
	always_comb begin
		addr_hit = 1'b1;
		rdata    = '0;
		case (apb_req.paddr)
			reg_ctrl:         rdata[ctrl_enable_bit] = cfg_q.enable;
			reg_kp:           rdata[coeff_w-1:0]     = cfg_q.kp;
			reg_ki:           rdata[coeff_w-1:0]     = cfg_q.ki;
			reg_setpoint:     rdata[sample_w-1:0]    = cfg_q.setpoint;
			reg_limit_hi:     rdata[sample_w-1:0]    = cfg_q.limit_hi;
			reg_limit_lo:     rdata[sample_w-1:0]    = cfg_q.limit_lo;
			reg_out_disabled: rdata[sample_w-1:0]    = cfg_q.out_disabled;
			reg_xdiff_offset: rdata[sample_w-1:0]    = xdiff_offset_q;
			reg_status:       rdata[status_w-1:0]    = sat_flags;
			default:          addr_hit               = 1'b0;
		endcase
	end

	// read data only on read access phases
	assign apb_rsp.prdata  = (access & ~apb_req.pwrite) ? rdata : '0;
	assign apb_rsp.pready  = 1'b1;
	// unmapped address, or write to read-only status
	assign apb_rsp.pslverr = access & (~addr_hit | status_wr);

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q          <= '0;
			cfg_q.limit_hi <= sat_pos;
			cfg_q.limit_lo <= sat_neg;
			xdiff_offset_q <= '0;
		end else begin
			// pi reset lasts a single cycle
			cfg_q.reset_pulse <= 1'b0;
			if (wr_en) begin
				case (apb_req.paddr)
					reg_ctrl: begin
						cfg_q.enable      <= apb_req.pwdata[ctrl_enable_bit];
						cfg_q.reset_pulse <= apb_req.pwdata[ctrl_reset_bit];
					end
					reg_kp:           cfg_q.kp           <= apb_req.pwdata[coeff_w-1:0];
					reg_ki:           cfg_q.ki           <= apb_req.pwdata[coeff_w-1:0];
					reg_setpoint:     cfg_q.setpoint     <= apb_req.pwdata[sample_w-1:0];
					reg_limit_hi:     cfg_q.limit_hi     <= apb_req.pwdata[sample_w-1:0];
					reg_limit_lo:     cfg_q.limit_lo     <= apb_req.pwdata[sample_w-1:0];
					reg_out_disabled: cfg_q.out_disabled <= apb_req.pwdata[sample_w-1:0];
					reg_xdiff_offset: xdiff_offset_q     <= apb_req.pwdata[sample_w-1:0];
					default: ;
				endcase
			end
		end
	end

	assign pi_cfg       = cfg_q;
	assign xdiff_offset = xdiff_offset_q;

endmodule

`default_nettype wire

// ==== lockin_dsp_pkg.sv ====
`default_nettype none

package lockin_dsp_pkg;

	// adc samples and fixed point format of the pi gains
	localparam int sample_w   = 16;
	localparam int coeff_w    = 26;
	// gains span -2 .. just under 2
	localparam int coeff_frac = 24;
	localparam int work_w     = 28;

	// dac side
	localparam int dac_w     = 16;
	localparam int n_dac     = 4;
	// minimum cs_n high time between frames, in clocks
	localparam int dac_gap   = 2;
	// attenuation of the position monitor output
	localparam int ray_shift = 3;
	// offset binary zero
	localparam logic [dac_w-1:0] dac_mid = 16'h8000;

	// adc full scale codes
	localparam logic [sample_w-1:0] sat_pos = 16'h7FFF;
	localparam logic [sample_w-1:0] sat_neg = 16'h8000;

	typedef struct packed {
		logic signed [sample_w-1:0] a;
		logic signed [sample_w-1:0] b;
		logic signed [sample_w-1:0] c;
		logic signed [sample_w-1:0] d;
	} adc_sample_t;

	typedef struct packed {
		logic                       enable;
		logic                       reset_pulse;
		logic signed [coeff_w-1:0]  kp;
		logic signed [coeff_w-1:0]  ki;
		logic signed [sample_w-1:0] setpoint;
		logic signed [sample_w-1:0] limit_hi;
		logic signed [sample_w-1:0] limit_lo;
		logic signed [sample_w-1:0] out_disabled;
	} pi_cfg_t;

	typedef struct packed {
		logic [dac_w-1:0] dac4;
		logic [dac_w-1:0] dac3;
		logic [dac_w-1:0] dac2;
		logic [dac_w-1:0] dac1;
	} dac_frame_t;

endpackage

`default_nettype wire

// ==== lockin_regs_pkg.sv ====
`default_nettype none

package lockin_regs_pkg;

	// apb bus geometry
	localparam int apb_addr_w = 8;
	localparam int apb_data_w = 32;

	// register map, byte addresses, word aligned
	localparam logic [apb_addr_w-1:0] reg_ctrl         = 8'h00;
	localparam logic [apb_addr_w-1:0] reg_kp           = 8'h04;
	localparam logic [apb_addr_w-1:0] reg_ki           = 8'h08;
	localparam logic [apb_addr_w-1:0] reg_setpoint     = 8'h0C;
	localparam logic [apb_addr_w-1:0] reg_limit_hi     = 8'h10;
	localparam logic [apb_addr_w-1:0] reg_limit_lo     = 8'h14;
	localparam logic [apb_addr_w-1:0] reg_out_disabled = 8'h18;
	localparam logic [apb_addr_w-1:0] reg_xdiff_offset = 8'h1C;
	localparam logic [apb_addr_w-1:0] reg_status       = 8'h20;

	// ctrl register bits
	localparam int ctrl_enable_bit = 0;
	// self clearing, always reads 0
	localparam int ctrl_reset_bit = 1;

	// status holds one saturation flag per adc channel, d in the msb
	localparam int status_w = 4;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [apb_data_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_w-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire
